/* verification/scope_trace.txt */
# c edg pos neg pre post | a arm | r reset | i cycles | s vld count samples...
# t name trg_addr | m name addr sample | d name busy done | f name closes a test
c 0 -100 100 1 3
a
s 1 6 0 50 150 90 110 95
d rise 0 1
t rise 2
m rise 2 150
m rise 1 50
f rise
c 1 -100 100 1 2
a
s 1 5 200 -50 -150 -120 30
d fall 0 1
t fall 2
m fall 2 -150
m fall 0 200
f fall
c 0 -100 100 3 2
a
s 1 7 -200 200 -200 0 300 10 20
d pre 0 1
t pre 4
m pre 4 300
m pre 1 200
f pre
c 0 -100 100 15 4
a
s 1 20 -200 5 10 15 20 25 30 35 40 45 50 55 60 65 70 250 80 85 90 95
d wrap 0 1
t wrap 15
m wrap 15 250
m wrap 14 70
m wrap 0 80
m wrap 3 95
m wrap 4 20
f wrap
c 0 -100 100 1 3
a
s 1 1 -200
s 0 3 500 500 500
s 1 1 150
s 0 2 -300 -300
s 1 1 7
i 3
d gap 1 0
t gap 1
m gap 1 150
m gap 2 7
a
d gap 1 0
s 1 3 -200 40 180
i 3
t gap 2
m gap 2 180
r
d gap 0 0
t gap 0
f gap

/* filelist.f */
src/scope_data_pkg.sv
src/scope_acq_pkg.sv
src/scope_stream_reg.sv
src/scope_edge.sv
src/scope_acq_ctl.sv
src/scope_buffer.sv
src/scope_top.sv
verification/scope_properties.sv
verification/scope_tb.sv

/* verification/scope_tb.sv */
/*
  Trace-driven testbench for the scope acquisition core.
  Commands and expected values come from verification/scope_trace.txt.
  Inputs change on the falling clock edge, outputs are checked there too.
*/

`timescale 1ns/1ps
`default_nettype none

module scope_tb;

  localparam int unsigned ADDR_W   = scope_acq_pkg::ADDR_W_DEF;
  localparam int          CLK_HALF = 10;
  localparam int          RST_CYC  = 10;
  localparam              TRACE    = "verification/scope_trace.txt";

  logic                 sti;
  logic                 ctl_rst;
  logic                 arm;
  logic                 cfg_edg;
  scope_data_pkg::smp_t cfg_pos;
  scope_data_pkg::smp_t cfg_neg;
  logic [ADDR_W-1:0]    cfg_pre;
  logic [ADDR_W-1:0]    cfg_post;
  logic                 smp_vld;
  scope_data_pkg::smp_t smp_in;
  logic [ADDR_W-1:0]    rd_addr;
  scope_data_pkg::smp_t rd_data;
  logic [ADDR_W-1:0]    trg_addr;
  logic                 acq_busy;
  logic                 acq_done;

  // trace handle and counters
  int fd;
  int err_cnt;
  int chk_cnt;
  int test_cnt;
  int test_err;

  scope_top #(
    .ADDR_W (ADDR_W)
  ) u_scope_top (
    .sti      (sti),
    .ctl_rst  (ctl_rst),
    .arm      (arm),
    .cfg_edg  (cfg_edg),
    .cfg_pos  (cfg_pos),
    .cfg_neg  (cfg_neg),
    .cfg_pre  (cfg_pre),
    .cfg_post (cfg_post),
    .smp_vld  (smp_vld),
    .smp_in   (smp_in),
    .rd_addr  (rd_addr),
    .rd_data  (rd_data),
    .trg_addr (trg_addr),
    .acq_busy (acq_busy),
    .acq_done (acq_done)
  );

  bind scope_acq_ctl scope_properties u_scope_properties (
    .sti      (sti),
    .ctl_rst  (ctl_rst),
    .arm      (arm),
    .state    (state),
    .buf_we   (buf_we),
    .acq_busy (acq_busy),
    .acq_done (acq_done)
  );

  // 20 ns period
  always #CLK_HALF sti = ~sti;

  ////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////

  task automatic check_value(input logic [8*16-1:0] tname, input int expected,
                             input int actual);
    chk_cnt++;
    if (expected != actual) begin
      err_cnt++;
      test_err++;
      $display("error %0s: expected %0d, actual %0d", tname, expected, actual);
    end
  endtask

  // count samples, each one cycle, strobe as given
  task automatic drive_samples(input int vld, input int count);
    int k;
    int val;
    int rc;
    for (k = 0; k < count; k++) begin
      rc = $fscanf(fd, "%d", val);
      smp_vld = vld[0];
      smp_in  = scope_data_pkg::smp_t'(val);
      @(negedge sti);
    end
    smp_vld = 1'b0;
  endtask

  ////////////////////////////////////////////////////////////
  // trace player
  ////////////////////////////////////////////////////////////

  initial begin : run_trace
    logic [8*16-1:0]  cmd;
    logic [8*16-1:0]  tname;
    logic [8*128-1:0] rest;
    int a0;
    int a1;
    int a2;
    int a3;
    int a4;
    int rc;
    int wait_cnt;
    int assert_cnt;
    sti      = 1'b0;
    ctl_rst  = 1'b1;
    arm      = 1'b0;
    cfg_edg  = 1'b0;
    cfg_pos  = '0;
    cfg_neg  = '0;
    cfg_pre  = '0;
    cfg_post = '0;
    smp_vld  = 1'b0;
    smp_in   = '0;
    rd_addr  = '0;
    err_cnt  = 0;
    chk_cnt  = 0;
    test_cnt = 0;
    test_err = 0;
    repeat (RST_CYC) @(negedge sti);
    ctl_rst = 1'b0;
    fd = $fopen(TRACE, "r");
    if (fd == 0) begin
      $display("could not open the trace file %0s", TRACE);
      err_cnt++;
    end else begin
      while ($fscanf(fd, "%s", cmd) == 1) begin
        case (cmd)
          "#": rc = $fgets(rest, fd);
          "c": begin
            rc = $fscanf(fd, "%d %d %d %d %d", a0, a1, a2, a3, a4);
            cfg_edg  = a0[0];
            cfg_pos  = scope_data_pkg::smp_t'(a1);
            cfg_neg  = scope_data_pkg::smp_t'(a2);
            cfg_pre  = a3[ADDR_W-1:0];
            cfg_post = a4[ADDR_W-1:0];
          end
          "a": begin
            arm = 1'b1;
            @(negedge sti);
            arm = 1'b0;
          end
          "r": begin
            ctl_rst = 1'b1;
            repeat (2) @(negedge sti);
            ctl_rst = 1'b0;
          end
          "i": begin
            rc = $fscanf(fd, "%d", a0);
            repeat (a0) @(negedge sti);
          end
          "s": begin
            rc = $fscanf(fd, "%d %d", a0, a1);
            drive_samples(a0, a1);
          end
          "t": begin
            rc = $fscanf(fd, "%s %d", tname, a0);
            check_value(tname, a0, trg_addr);
          end
          "m": begin
            // read data one cycle after the address
            rc = $fscanf(fd, "%s %d %d", tname, a0, a1);
            rd_addr = a0[ADDR_W-1:0];
            @(negedge sti);
            check_value(tname, a1, rd_data);
          end
          "d": begin
            rc = $fscanf(fd, "%s %d %d", tname, a0, a1);
            wait_cnt = 0;
            // done needs the pipeline drained, bounded wait
            while (a1 != 0 && !acq_done && wait_cnt < 16) begin
              @(negedge sti);
              wait_cnt++;
            end
            check_value(tname, a0, acq_busy);
            check_value(tname, a1, acq_done);
          end
          "f": begin
            rc = $fscanf(fd, "%s", tname);
            test_cnt++;
            if (test_err == 0) begin
              $display("%0s: ok", tname);
            end else begin
              $display("%0s: %0d mismatches", tname, test_err);
            end
            test_err = 0;
          end
          default: begin
            $display("unknown command in the trace, rest of its line skipped");
            err_cnt++;
            rc = $fgets(rest, fd);
          end
        endcase
      end
      $fclose(fd);
    end
    assert_cnt = u_scope_top.u_scope_acq_ctl.u_scope_properties.fail_cnt;
    err_cnt    = err_cnt + assert_cnt;
    $display("tests %0d, checks %0d, errors %0d, assertion failures %0d",
             test_cnt, chk_cnt, err_cnt, assert_cnt);
    if (err_cnt == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  ////////////////////////////////////////////////////////////
  // watchdog
  ////////////////////////////////////////////////////////////

  // budget of four cycles per trace field plus reset
  initial begin : watchdog
    logic [8*128-1:0] tok;
    logic [8*128-1:0] rest;
    int wfd;
    int words;
    int rc;
    words = 0;
    wfd   = $fopen(TRACE, "r");
    if (wfd != 0) begin
      while ($fscanf(wfd, "%s", tok) == 1) begin
        if (tok == "#") begin
          rc = $fgets(rest, wfd);
        end else begin
          words++;
        end
      end
      $fclose(wfd);
    end
    #((words + RST_CYC) * 2 * CLK_HALF * 4);
    $display("the run timed out before the trace was finished");
    $display("Test failed");
    $finish;
  end

endmodule

`default_nettype wire

/* verification/scope_properties.sv */
/*
  Concurrent checks on the acquisition FSM status and write strobe.
  Bound into scope_acq_ctl by the testbench.
*/

`timescale 1ns/1ps
`default_nettype none

module scope_properties (
  input logic                      sti,
  input logic                      ctl_rst,
  input logic                      arm,
  input scope_acq_pkg::acq_state_t state,
  input logic                      buf_we,
  input logic                      acq_busy,
  input logic                      acq_done
);

  // number of failed checks so far
  int fail_cnt = 0;

  // idle and done hold without an arm, so no write follows them
  a_we_stopped: assert property (
    @(posedge sti) disable iff (ctl_rst)
    (((state == scope_acq_pkg::ACQ_IDLE) || (state == scope_acq_pkg::ACQ_DONE)) && !arm)
      |=> !buf_we
  ) else begin
    fail_cnt++;
    $error("buffer written after idle or done without an arm");
  end

  // done only reached from a running phase
  a_done_entry: assert property (
    @(posedge sti) disable iff (ctl_rst)
    $rose(acq_done) |-> $past(acq_busy)
  ) else begin
    fail_cnt++;
    $error("acq_done set without a running acquisition before it");
  end

  // both status flags cleared by reset
  a_rst_clear: assert property (
    @(posedge sti) ctl_rst |=> (!acq_busy && !acq_done)
  ) else begin
    fail_cnt++;
    $error("status flags still set one cycle after reset");
  end

endmodule

`default_nettype wire

/* src/scope_top.sv */
/*
  Acquisition core of one scope channel.
  Edge detector feeds the controller, which writes the delayed
  samples into the circular buffer. Readout works in any state.
*/

`timescale 1ns/1ps
`default_nettype none

module scope_top #(
  parameter int unsigned ADDR_W = scope_acq_pkg::ADDR_W_DEF
)(
  input  logic                 sti,
  input  logic                 ctl_rst,
  input  logic                 arm,
  // trigger configuration
  input  logic                 cfg_edg,
  input  scope_data_pkg::smp_t cfg_pos,
  input  scope_data_pkg::smp_t cfg_neg,
  // window lengths
  input  logic [ADDR_W-1:0]    cfg_pre,
  input  logic [ADDR_W-1:0]    cfg_post,
  // sample stream
  input  logic                 smp_vld,
  input  scope_data_pkg::smp_t smp_in,
  // readout
  input  logic [ADDR_W-1:0]    rd_addr,
  output scope_data_pkg::smp_t rd_data,
  output logic [ADDR_W-1:0]    trg_addr,
  output logic                 acq_busy,
  output logic                 acq_done
);

  // delayed stream out of the edge detector
  logic                 trg_vld;
  scope_data_pkg::smp_t trg_smp;
  logic                 trg_flag;

  // buffer write side
  logic              buf_we;
  logic [ADDR_W-1:0] wr_addr;

  scope_edge u_scope_edge (
    .sti      (sti),
    .ctl_rst  (ctl_rst),
    .cfg_edg  (cfg_edg),
    .cfg_pos  (cfg_pos),
    .cfg_neg  (cfg_neg),
    .smp_vld  (smp_vld),
    .smp_in   (smp_in),
    .trg_vld  (trg_vld),
    .trg_smp  (trg_smp),
    .trg_flag (trg_flag)
  );

  scope_acq_ctl #(
    .ADDR_W (ADDR_W)
  ) u_scope_acq_ctl (
    .sti      (sti),
    .ctl_rst  (ctl_rst),
    .arm      (arm),
    .cfg_pre  (cfg_pre),
    .cfg_post (cfg_post),
    .trg_vld  (trg_vld),
    .trg_flag (trg_flag),
    .buf_we   (buf_we),
    .wr_addr  (wr_addr),
    .trg_addr (trg_addr),
    .acq_busy (acq_busy),
    .acq_done (acq_done)
  );

  // buffer holds the delayed sample, aligned with the flag
  scope_buffer #(
    .ADDR_W (ADDR_W),
    .DT     (scope_data_pkg::smp_t)
  ) u_scope_buffer (
    .sti     (sti),
    .we      (buf_we),
    .wr_addr (wr_addr),
    .wr_data (trg_smp),
    .rd_addr (rd_addr),
    .rd_data (rd_data)
  );

endmodule

`default_nettype wire

/* src/scope_buffer.sv */
/*
  Circular sample memory, simple dual port.
  Strobed write, registered read with one cycle latency.
  Maps onto block RAM.
*/

`timescale 1ns/1ps
`default_nettype none

module scope_buffer #(
  parameter int unsigned ADDR_W = scope_acq_pkg::ADDR_W_DEF,
  parameter type         DT     = scope_data_pkg::smp_t
)(
  input  logic              sti,
  input  logic              we,
  input  logic [ADDR_W-1:0] wr_addr,
  input  DT                 wr_data,
  input  logic [ADDR_W-1:0] rd_addr,
  output DT                 rd_data
);

  localparam int unsigned DEPTH = 2**ADDR_W;

  // sample storage
  DT mem [DEPTH];

  ////////////////////////////////////////////////////////////
  // write port
  ////////////////////////////////////////////////////////////

  always_ff @(posedge sti) begin
    if (we) begin
      mem[wr_addr] <= wr_data;
    end
  end

  ////////////////////////////////////////////////////////////
  // read port
  ////////////////////////////////////////////////////////////

  // data valid one cycle after the address
  always_ff @(posedge sti) begin
    rd_data <= mem[rd_addr];
  end

endmodule

`default_nettype wire

/* src/scope_acq_ctl.sv */
/*
  Acquisition FSM. An arm strobe starts the pre-trigger fill,
  then the trigger wait and the post-trigger count. Drives the
  buffer write strobe and pointer, and latches the trigger address.
*/

`timescale 1ns/1ps
`default_nettype none

module scope_acq_ctl #(
  parameter int unsigned ADDR_W = scope_acq_pkg::ADDR_W_DEF
)(
  input  logic              sti,
  input  logic              ctl_rst,
  input  logic              arm,
  input  logic [ADDR_W-1:0] cfg_pre,
  input  logic [ADDR_W-1:0] cfg_post,
  input  logic              trg_vld,
  input  logic              trg_flag,
  output logic              buf_we,
  output logic [ADDR_W-1:0] wr_addr,
  output logic [ADDR_W-1:0] trg_addr,
  output logic              acq_busy,
  output logic              acq_done
);

  scope_acq_pkg::acq_state_t state;

  logic [ADDR_W-1:0] pre_cnt;
  logic [ADDR_W-1:0] post_cnt;
  logic [ADDR_W-1:0] pre_nxt;
  logic [ADDR_W-1:0] post_nxt;

  // counts after this sample
  assign pre_nxt  = pre_cnt + 1'b1;
  assign post_nxt = post_cnt + 1'b1;

  ////////////////////////////////////////////////////////////
  // status and write strobe
  ////////////////////////////////////////////////////////////

  assign acq_busy = (state == scope_acq_pkg::ACQ_PRE)  ||
                    (state == scope_acq_pkg::ACQ_WAIT) ||
                    (state == scope_acq_pkg::ACQ_POST);
  assign acq_done = (state == scope_acq_pkg::ACQ_DONE);

  // every delayed sample is stored while running
  assign buf_we = trg_vld & acq_busy;

  ////////////////////////////////////////////////////////////
  // state machine
  ////////////////////////////////////////////////////////////

  always_ff @(posedge sti) begin
    if (ctl_rst) begin
      state    <= scope_acq_pkg::ACQ_IDLE;
      pre_cnt  <= '0;
      post_cnt <= '0;
      wr_addr  <= '0;
      trg_addr <= '0;
    end else if (arm) begin
      // restart from any state
      pre_cnt  <= '0;
      post_cnt <= '0;
      wr_addr  <= '0;
      // empty window skips straight to the trigger wait
      state    <= (cfg_pre == '0) ? scope_acq_pkg::ACQ_WAIT : scope_acq_pkg::ACQ_PRE;
    end else if (trg_vld) begin
      // pointer wraps at the buffer depth
      if (acq_busy) begin
        wr_addr <= wr_addr + 1'b1;
      end
      unique case (state)
        scope_acq_pkg::ACQ_PRE: begin
          // flags ignored until the window is full
          pre_cnt <= pre_nxt;
          if (pre_nxt == cfg_pre) begin
            state <= scope_acq_pkg::ACQ_WAIT;
          end
        end
        scope_acq_pkg::ACQ_WAIT: begin
          if (trg_flag) begin
            // trigger sample lands at the current pointer
            trg_addr <= wr_addr;
            state    <= (cfg_post == '0) ? scope_acq_pkg::ACQ_DONE
                                         : scope_acq_pkg::ACQ_POST;
          end
        end
        scope_acq_pkg::ACQ_POST: begin
          post_cnt <= post_nxt;
          if (post_nxt == cfg_post) begin
            state <= scope_acq_pkg::ACQ_DONE;
          end
        end
        // idle and done drop samples
        default: begin
          state <= state;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

/* src/scope_edge.sv */
/*
  Edge detector with hysteresis for the sample stream.
  Stage one subtracts both levels, stage two tracks the level
  state and flags the inactive to active transition.
  Outputs follow the input strobe by exactly two cycles.
*/

`timescale 1ns/1ps
`default_nettype none

module scope_edge (
  input  logic                 sti,
  input  logic                 ctl_rst,
  input  logic                 cfg_edg,
  input  scope_data_pkg::smp_t cfg_pos,
  input  scope_data_pkg::smp_t cfg_neg,
  input  logic                 smp_vld,
  input  scope_data_pkg::smp_t smp_in,
  output logic                 trg_vld,
  output scope_data_pkg::smp_t trg_smp,
  output logic                 trg_flag
);

  // sign bit position of the widened differences
  localparam int unsigned SGN = $bits(scope_data_pkg::smp_t);

  logic signed [SGN:0] sub_pos;
  logic signed [SGN:0] sub_neg;

  // delayed stream after subtraction
  logic                 sub_vld;
  scope_data_pkg::smp_t sub_smp;

  // level state, next and registered
  logic lvl_nxt;
  logic lvl_reg;

  scope_data_pkg::smp_trg_t trg_in;
  scope_data_pkg::smp_trg_t trg_out;

  ////////////////////////////////////////////////////////////
  // subtraction stage
  ////////////////////////////////////////////////////////////

  // one extra bit so the difference never overflows
  always_ff @(posedge sti) begin
    if (smp_vld) begin
      sub_pos <= (SGN+1)'(smp_in) - (SGN+1)'(cfg_pos);
      sub_neg <= (SGN+1)'(cfg_neg) - (SGN+1)'(smp_in);
    end
  end

  scope_stream_reg #(
    .DT (scope_data_pkg::smp_t)
  ) u_reg_sub (
    .sti     (sti),
    .ctl_rst (ctl_rst),
    .vld_i   (smp_vld),
    .dat_i   (smp_in),
    .vld_o   (sub_vld),
    .dat_o   (sub_smp)
  );

  ////////////////////////////////////////////////////////////
  // trigger stage
  ////////////////////////////////////////////////////////////

  // inactive watches the far level, active watches the near one
  // edge select swaps which level is which
  assign lvl_nxt = lvl_reg ^ ((~cfg_edg ^ lvl_reg) ? sub_neg[SGN] : sub_pos[SGN]);

  always_ff @(posedge sti) begin
    if (ctl_rst) begin
      lvl_reg <= 1'b0;
    end else if (sub_vld) begin
      lvl_reg <= lvl_nxt;
    end
  end

  // tag the sample on an inactive to active change
  assign trg_in = '{smp: sub_smp, trg: lvl_nxt & ~lvl_reg};

  scope_stream_reg #(
    .DT (scope_data_pkg::smp_trg_t)
  ) u_reg_trg (
    .sti     (sti),
    .ctl_rst (ctl_rst),
    .vld_i   (sub_vld),
    .dat_i   (trg_in),
    .vld_o   (trg_vld),
    .dat_o   (trg_out)
  );

  assign trg_smp  = trg_out.smp;
  // held tag only counts on its own strobe
  assign trg_flag = trg_vld & trg_out.trg;

endmodule

`default_nettype wire

/* src/scope_stream_reg.sv */
/*
  One-cycle register stage for a strobed stream.
  The payload type is a parameter, so the same stage carries
  plain samples or tagged records.
*/

`timescale 1ns/1ps
`default_nettype none

module scope_stream_reg #(
  parameter type DT = logic
)(
  input  logic sti,
  input  logic ctl_rst,
  input  logic vld_i,
  input  DT    dat_i,
  output logic vld_o,
  output DT    dat_o
);

  // strobe delayed by one cycle
  always_ff @(posedge sti) begin
    if (ctl_rst) begin
      vld_o <= 1'b0;
    end else begin
      vld_o <= vld_i;
    end
  end

  // payload only loads on a strobe and holds in between
  always_ff @(posedge sti) begin
    if (vld_i) begin
      dat_o <= dat_i;
    end
  end

endmodule

`default_nettype wire

/* src/scope_acq_pkg.sv */
/*
  Acquisition control definitions.
  State encoding of the acquisition FSM and the default
  address width of the circular sample buffer.
*/

`default_nettype none

package scope_acq_pkg;

  // default buffer address width, 16 entries
  parameter int unsigned ADDR_W_DEF = 4;

  // acquisition phases
  // pre fills the window, wait looks for the trigger,
  // post counts the samples after it
  typedef enum logic [2:0] {
    ACQ_IDLE = 3'd0,
    ACQ_PRE  = 3'd1,
    ACQ_WAIT = 3'd2,
    ACQ_POST = 3'd3,
    ACQ_DONE = 3'd4
  } acq_state_t;

endpackage

`default_nettype wire

/* src/scope_data_pkg.sv */
/*
  Sample data definitions for the scope acquisition core.
  Holds the sample width, the signed sample type and the
  trigger-tagged record that leaves the edge detector.
*/

`default_nettype none

package scope_data_pkg;

  // sample width in bits, one word
  parameter int unsigned SMP_W = 16;

  // signed ADC sample
  typedef logic signed [SMP_W-1:0] smp_t;

  // sample tagged with the trigger flag
  // trg marks the sample that caused the crossing
  typedef struct packed {
    smp_t smp;
    logic trg;
  } smp_trg_t;

endpackage

`default_nettype wire
